/* logic/cpuIsaPkg.sv */
`default_nettype none

package cpuIsaPkg;

    localparam int WORD_WIDTH    = 32;
    localparam int REG_IDX_WIDTH = 4;
    localparam int IMM_WIDTH     = 12;
    localparam int VECTOR_WIDTH  = 5;
    localparam int OP_WIDTH      = 4;

    typedef logic [WORD_WIDTH-1:0]    word_t;
    typedef logic [REG_IDX_WIDTH-1:0] regIdx_t;
    typedef logic [IMM_WIDTH-1:0]     imm_t;
    typedef logic [VECTOR_WIDTH-1:0]  vector_t;

    // Instruction word layout, high to low
    localparam int THROW_BIT = 31;     // Throw class when set together with kind
    localparam int KIND_BIT  = 30;     // Immediate is the operand, Y the addend
    localparam int STORE_BIT = 29;
    localparam int DEREF_BIT = 28;
    localparam int Z_LSB     = 24;
    localparam int X_LSB     = 20;
    localparam int Y_LSB     = 16;
    localparam int OP_LSB    = 12;
    localparam int IMM_LSB   = 0;

    localparam regIdx_t PC_INDEX = regIdx_t'(15);

    typedef enum logic [OP_WIDTH-1:0] {
        opOr    = 4'h0,
        opAnd   = 4'h1,
        opAdd   = 4'h2,
        opMul   = 4'h3,
        opRsvd4 = 4'h4,        // Yields the addend alone
        opShl   = 4'h5,
        opLt    = 4'h6,
        opEq    = 4'h7,
        opGt    = 4'h8,
        opAndN  = 4'h9,
        opXor   = 4'ha,
        opSub   = 4'hb,
        opXnor  = 4'hc,
        opShr   = 4'hd,
        opNe    = 4'he,
        opRsvdF = 4'hf
    } aluOp_e;

endpackage

`default_nettype wire

/* logic/cpuSysPkg.sv */
`default_nettype none

package cpuSysPkg;

    localparam int TIMER_WIDTH = 16;

    typedef logic [TIMER_WIDTH-1:0] timerCount_t;

    // Word addresses in the shared memory map
    localparam cpuIsaPkg::word_t RESET_VECTOR = 32'h0000_0100;
    localparam cpuIsaPkg::word_t VECTOR_BASE  = 32'h0000_0020;  // Throw table, 32 entries
    localparam cpuIsaPkg::word_t TRAP_ADDR    = 32'h0000_0010;  // Interrupted address cell
    localparam cpuIsaPkg::word_t TRAMP_BOTTOM = 32'h0000_0200;  // Timer trap handler

    typedef enum logic [3:0] {
        stIdle       = 4'd0,
        stExec       = 4'd1,   // Decode, register read, ALU
        stLatch      = 4'd2,
        stMulWait    = 4'd3,
        stMem        = 4'd4,
        stWriteback  = 4'd5,   // Register write and next fetch address
        stPcAdvance  = 4'd6,
        stThrow      = 4'd7,
        stVecRead    = 4'd8,
        stTimerFault = 4'd9,
        stTrapSave   = 4'd10,
        stTrapWrite  = 4'd11
    } ctrlState_e;

endpackage

`default_nettype wire

/* logic/decodeIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;

    import cpuIsaPkg::*;

    regIdx_t zIdx;
    regIdx_t xIdx;
    regIdx_t yIdx;
    imm_t    imm;
    aluOp_e  op;
    logic    kind;
    logic    storing;
    logic    derefRhs;
    logic    branch;
    logic    isThrow;
    vector_t vector;

    modport producer (output zIdx, xIdx, yIdx, imm, op, kind,
                      output storing, derefRhs, branch, isThrow, vector);

    modport datapath (input zIdx, xIdx, yIdx, imm, op, kind);

    modport control (input storing, derefRhs, branch, isThrow, vector);

endinterface

`default_nettype wire

/* logic/insnDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insnDecoder (
    input  cpuIsaPkg::word_t iData,
    decodeIf.producer        dec
);

    import cpuIsaPkg::*;

    // Register indices
    assign dec.zIdx = iData[Z_LSB +: REG_IDX_WIDTH];
    assign dec.xIdx = iData[X_LSB +: REG_IDX_WIDTH];
    assign dec.yIdx = iData[Y_LSB +: REG_IDX_WIDTH];

    assign dec.imm = iData[IMM_LSB +: IMM_WIDTH];
    assign dec.op  = aluOp_e'(iData[OP_LSB +: OP_WIDTH]);

    // Flags
    assign dec.kind     = iData[KIND_BIT];
    assign dec.storing  = iData[STORE_BIT];
    assign dec.derefRhs = iData[DEREF_BIT];

    assign dec.isThrow = iData[THROW_BIT] & iData[KIND_BIT];
    assign dec.vector  = iData[VECTOR_WIDTH-1:0];      // Throw vector in the low bits

    // Writing the PC without storing is a jump
    assign dec.branch = (dec.zIdx == PC_INDEX) && !dec.storing;

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic             clk,
    input  logic             writeEn,
    input  cpuIsaPkg::word_t writeData,
    input  cpuIsaPkg::word_t nextPc,
    output cpuIsaPkg::word_t valueX,
    output cpuIsaPkg::word_t valueY,
    output cpuIsaPkg::word_t valueZ,
    decodeIf.datapath        dec
);

    import cpuIsaPkg::*;

    word_t store [0:14];

    // Register 0 is hardwired, register 15 is the next PC
    function automatic word_t readReg(input regIdx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (idx == PC_INDEX) begin
            return nextPc;
        end
        return store[idx];
    endfunction

    assign valueX = readReg(dec.xIdx);
    assign valueY = readReg(dec.yIdx);
    assign valueZ = readReg(dec.zIdx);

    always_ff @(posedge clk) begin
        if (writeEn && dec.zIdx != '0 && dec.zIdx != PC_INDEX) begin
            store[dec.zIdx] <= writeData;   // PC writes are branches only
        end
    end

    // Write target held since the memory cycle
    writeIdxSteady: assert property (@(posedge clk)
        writeEn |-> $stable(dec.zIdx));

endmodule

`default_nettype wire

/* logic/aluExec.sv */
`timescale 1ns/1ps
`default_nettype none

module aluExec (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             execEn,
    input  cpuIsaPkg::word_t valueX,
    input  cpuIsaPkg::word_t valueY,
    decodeIf.datapath        dec,
    output cpuIsaPkg::word_t aluResult
);

    import cpuIsaPkg::*;

    word_t immExt;
    word_t operand;
    word_t addend;
    word_t opResult;

    assign immExt = {{(WORD_WIDTH-IMM_WIDTH){dec.imm[IMM_WIDTH-1]}}, dec.imm};

    // Kind swaps immediate and Y between operand and addend
    assign operand = dec.kind ? immExt : valueY;
    assign addend  = dec.kind ? valueY : immExt;

    function automatic word_t truthMask(input logic cond);
        return cond ? '1 : '0;
    endfunction

    always_comb begin
        case (dec.op)
            opOr:    opResult = valueX | operand;
            opAnd:   opResult = valueX & operand;
            opAdd:   opResult = valueX + operand;
            opMul:   opResult = valueX * operand;       // Low word of the product
            opShl:   opResult = valueX << operand;
            opLt:    opResult = truthMask($signed(valueX) < $signed(operand));
            opEq:    opResult = truthMask(valueX == operand);
            opGt:    opResult = truthMask($signed(valueX) > $signed(operand));
            opAndN:  opResult = valueX & ~operand;
            opXor:   opResult = valueX ^ operand;
            opSub:   opResult = valueX - operand;
            opXnor:  opResult = valueX ^~ operand;
            opShr:   opResult = valueX >> operand;
            opNe:    opResult = truthMask(valueX != operand);
            default: opResult = '0;                     // Reserved, addend passes alone
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            aluResult <= '0;
        end else if (execEn) begin
            aluResult <= opResult + addend;
        end
    end

endmodule

`default_nettype wire

/* logic/cycleTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module cycleTimer (
    input  logic                   clk,
    input  logic                   reset_n,
    input  cpuSysPkg::timerCount_t period,
    input  logic                   trapAck,
    output logic                   trapPending
);

    import cpuSysPkg::*;

    timerCount_t count;
    timerCount_t countNext;

    assign countNext = count + 1'b1;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count       <= '0;
            trapPending <= 1'b0;
        end else if (trapAck) begin
            count       <= '0;
            trapPending <= 1'b0;
        end else if (period != '0 && !trapPending) begin   // Zero period disables
            count <= countNext;
            if (countNext == period) begin
                trapPending <= 1'b1;       // Held until the core acknowledges
            end
        end
    end

    // The core may only acknowledge a request it has seen
    ackNeedsPending: assert property (@(posedge clk) disable iff (!reset_n)
        trapAck |-> trapPending);

endmodule

`default_nettype wire

/* logic/coreControl.sv */
`timescale 1ns/1ps
`default_nettype none

module coreControl (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             halt,
    input  logic             trapPending,
    output logic             trapAck,
    decodeIf.control         dec,
    input  cpuIsaPkg::word_t aluResult,
    input  cpuIsaPkg::word_t valueZ,
    output logic             execEn,
    output logic             writeEn,
    output cpuIsaPkg::word_t writeData,
    output cpuIsaPkg::word_t nextPc,
    output cpuIsaPkg::word_t iAddr,
    output logic             strobe,
    output logic             memRw,
    output cpuIsaPkg::word_t dAddr,
    output cpuIsaPkg::word_t dOut,
    input  cpuIsaPkg::word_t dIn
);

    import cpuIsaPkg::*;
    import cpuSysPkg::*;

    ctrlState_e state;
    word_t      resultLatch;       // ALU result, vector address or saved iAddr
    word_t      loadData;
    word_t      vectorReg;         // Target of a throw or timer trap
    word_t      rhs;
    logic       loading;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state  <= stIdle;
            iAddr  <= RESET_VECTOR;
            nextPc <= RESET_VECTOR;
        end else begin
            case (state)
                stIdle: begin
                    state <= halt ? stIdle : stPcAdvance;
                    iAddr <= RESET_VECTOR;
                end
                stExec: begin
                    if (halt) begin
                        state <= stIdle;
                    end else if (trapPending) begin
                        state <= stTimerFault;
                    end else if (dec.isThrow) begin
                        state <= stThrow;
                    end else begin
                        state <= stLatch;
                    end
                end
                stLatch: begin
                    state       <= stMulWait;
                    resultLatch <= aluResult;
                end
                stMulWait:   state <= stMem;           // Slack for the multiplier
                stMem: begin
                    state    <= stWriteback;
                    loadData <= dIn;
                end
                stWriteback: begin
                    state <= stPcAdvance;
                    iAddr <= dec.branch ? rhs : nextPc;
                end
                stPcAdvance: begin
                    state  <= stExec;
                    nextPc <= iAddr + 1'b1;
                end
                stThrow: begin
                    state       <= stVecRead;
                    resultLatch <= VECTOR_BASE + word_t'(dec.vector);
                end
                stVecRead: begin
                    state     <= stTrapSave;
                    vectorReg <= dIn;                  // Table entry
                end
                stTimerFault: begin
                    state     <= stTrapSave;
                    vectorReg <= TRAMP_BOTTOM;
                end
                stTrapSave: begin
                    state       <= stTrapWrite;
                    resultLatch <= iAddr;              // Interrupted fetch address
                end
                stTrapWrite: begin
                    state <= stPcAdvance;
                    iAddr <= vectorReg;
                end
                default: state <= stIdle;
            endcase
        end
    end

    assign execEn  = (state == stExec);
    assign trapAck = (state == stTimerFault);

    // Loaded word replaces the result for dereferenced reads
    assign rhs       = dec.derefRhs ? loadData : resultLatch;
    assign writeData = rhs;
    assign writeEn   = (state == stWriteback) && !dec.storing;

    assign loading = dec.derefRhs && !dec.storing;
    assign strobe  = (state == stMem && (loading || dec.storing)) ||
                     state == stVecRead || state == stTrapWrite;
    assign memRw   = (state == stMem && dec.storing) || state == stTrapWrite;

    always_comb begin
        if (state == stTrapWrite) begin
            dAddr = TRAP_ADDR;
            dOut  = resultLatch;
        end else if (state == stVecRead || dec.derefRhs) begin
            dAddr = resultLatch;
            dOut  = valueZ;
        end else begin
            dAddr = valueZ;
            dOut  = resultLatch;
        end
    end

    // ALU output must hold from latch to writeback
    resultHeld: assert property (@(posedge clk) disable iff (!reset_n)
        (state inside {stMulWait, stMem, stWriteback}) |-> aluResult == resultLatch);

endmodule

`default_nettype wire

/* logic/cpuCore.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  logic                   clk,
    input  logic                   reset_n,
    output cpuIsaPkg::word_t       iAddr,
    input  cpuIsaPkg::word_t       iData,
    output logic                   strobe,
    output logic                   memRw,
    output cpuIsaPkg::word_t       dAddr,
    output cpuIsaPkg::word_t       dOut,
    input  cpuIsaPkg::word_t       dIn,
    input  logic                   halt,
    input  cpuSysPkg::timerCount_t timerPeriod    // Zero disables the timer
);

    import cpuIsaPkg::*;

    word_t valueX;
    word_t valueY;
    word_t valueZ;
    word_t aluResult;
    word_t writeData;
    word_t nextPc;
    logic  execEn;
    logic  writeEn;
    logic  trapPending;
    logic  trapAck;

    decodeIf decBus ();

    insnDecoder decoder0 (
        .iData (iData),
        .dec   (decBus.producer)
    );

    regFile regs0 (
        .clk       (clk),
        .writeEn   (writeEn),
        .writeData (writeData),
        .nextPc    (nextPc),
        .valueX    (valueX),
        .valueY    (valueY),
        .valueZ    (valueZ),
        .dec       (decBus.datapath)
    );

    aluExec alu0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .execEn    (execEn),
        .valueX    (valueX),
        .valueY    (valueY),
        .dec       (decBus.datapath),
        .aluResult (aluResult)
    );

    cycleTimer timer0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .period      (timerPeriod),
        .trapAck     (trapAck),
        .trapPending (trapPending)
    );

    coreControl control0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .halt        (halt),
        .trapPending (trapPending),
        .trapAck     (trapAck),
        .dec         (decBus.control),
        .aluResult   (aluResult),
        .valueZ      (valueZ),
        .execEn      (execEn),
        .writeEn     (writeEn),
        .writeData   (writeData),
        .nextPc      (nextPc),
        .iAddr       (iAddr),
        .strobe      (strobe),
        .memRw       (memRw),
        .dAddr       (dAddr),
        .dOut        (dOut),
        .dIn         (dIn)
    );

endmodule

`default_nettype wire

/* dv/cpuCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

    import cpuIsaPkg::*;
    import cpuSysPkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int HALT_CYCLES  = 20;
    localparam int ADDR_BITS    = 10;
    localparam int MEM_WORDS    = 1 << ADDR_BITS;
    localparam int TIMED_PAIRS  = 24;           // ALU and store pairs run with the timer on
    localparam logic [31:0] SEED = 32'hc80e3d4f;

    // Flag nibble is throw, kind, store, deref
    localparam logic [3:0] FL_NONE  = 4'b0000;
    localparam logic [3:0] FL_LOAD  = 4'b0001;
    localparam logic [3:0] FL_STORE = 4'b0011;  // Z goes to the result address
    localparam logic [3:0] FL_THROW = 4'b1100;

    logic        clk;
    logic        reset_n;
    logic        halt;
    timerCount_t timerPeriod;
    word_t       iAddr;
    word_t       iData;
    logic        strobe;
    logic        memRw;
    word_t       dAddr;
    word_t       dOut;
    word_t       dIn;

    word_t imem [0:MEM_WORDS-1];
    word_t dmem [0:MEM_WORDS-1];
    word_t refMem [0:MEM_WORDS-1];
    word_t refRegs [0:15];
    word_t refPc;

    word_t       buildPc;
    word_t       storeSlot;
    word_t       timerStart;
    word_t       endAddr;
    timerCount_t trapPeriod;
    int          programLen;
    int          errorCount;
    int          fetchCount;
    int          storeCount;
    int          trapCount;
    int unsigned seedValue;

    word_t curInsn;
    logic  pendingInsn;                         // Fetched, not yet stepped in the model
    logic  timerPhase;
    logic  progDone;
    logic  expIsStore;
    word_t expAddr;
    word_t expData;

    cpuCore dut0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .iAddr       (iAddr),
        .iData       (iData),
        .strobe      (strobe),
        .memRw       (memRw),
        .dAddr       (dAddr),
        .dOut        (dOut),
        .dIn         (dIn),
        .halt        (halt),
        .timerPeriod (timerPeriod)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Both memories read combinationally, data writes land on the clock
    assign iData = imem[iAddr[ADDR_BITS-1:0]];
    assign dIn   = dmem[dAddr[ADDR_BITS-1:0]];

    always @(posedge clk) begin
        if (strobe && memRw) begin
            dmem[dAddr[ADDR_BITS-1:0]] <= dOut;
        end
    end

    function automatic logic [ADDR_BITS-1:0] wordIndex(input word_t addr);
        return addr[ADDR_BITS-1:0];
    endfunction

    function automatic word_t encodeInsn(input logic [3:0] flags, input regIdx_t z,
                                         input regIdx_t x, input regIdx_t y,
                                         input logic [3:0] op, input imm_t imm);
        return {flags, z, x, y, op, imm};
    endfunction

    function automatic word_t regValue(input regIdx_t idx, input word_t pcNext);
        if (idx == 4'd0) begin
            return '0;
        end else if (idx == PC_INDEX) begin
            return pcNext;
        end
        return refRegs[idx];
    endfunction

    // Executes one instruction on the model state
    function automatic void refStep(input word_t insn, output logic isStore,
                                    output word_t stAddr, output word_t stData);
        word_t   pcNext;
        word_t   x;
        word_t   y;
        word_t   immExt;
        word_t   operand;
        word_t   addend;
        word_t   opValue;
        word_t   result;
        word_t   rhs;
        regIdx_t zIdx;
        pcNext  = refPc + 1;
        isStore = 1'b0;
        stAddr  = '0;
        stData  = '0;
        zIdx    = insn[27:24];
        if (insn[31] && insn[30]) begin
            isStore = 1'b1;                     // Throw saves its own address
            stAddr  = TRAP_ADDR;
            stData  = refPc;
            refMem[wordIndex(TRAP_ADDR)] = refPc;
            refPc = refMem[wordIndex(VECTOR_BASE + word_t'(insn[4:0]))];
            return;
        end
        x       = regValue(insn[23:20], pcNext);
        y       = regValue(insn[19:16], pcNext);
        immExt  = {{20{insn[11]}}, insn[11:0]};
        operand = insn[30] ? immExt : y;
        addend  = insn[30] ? y : immExt;
        case (insn[15:12])
            opOr:    opValue = x | operand;
            opAnd:   opValue = x & operand;
            opAdd:   opValue = x + operand;
            opMul:   opValue = x * operand;
            opShl:   opValue = x << operand;
            opLt:    opValue = {32{$signed(x) < $signed(operand)}};
            opEq:    opValue = {32{x == operand}};
            opGt:    opValue = {32{$signed(x) > $signed(operand)}};
            opAndN:  opValue = x & ~operand;
            opXor:   opValue = x ^ operand;
            opSub:   opValue = x - operand;
            opXnor:  opValue = ~(x ^ operand);
            opShr:   opValue = x >> operand;
            opNe:    opValue = {32{x != operand}};
            default: opValue = '0;              // Reserved codes
        endcase
        result = opValue + addend;
        if (insn[29]) begin
            isStore = 1'b1;
            stAddr  = insn[28] ? result : regValue(zIdx, pcNext);
            stData  = insn[28] ? regValue(zIdx, pcNext) : result;
            refMem[wordIndex(stAddr)] = stData;
            refPc = pcNext;
        end else begin
            rhs = insn[28] ? refMem[wordIndex(result)] : result;
            if (zIdx == PC_INDEX) begin
                refPc = rhs;                    // Branch
            end else begin
                if (zIdx != 4'd0) begin
                    refRegs[zIdx] = rhs;
                end
                refPc = pcNext;
            end
        end
    endfunction

    task automatic reportMismatch(input string name, input word_t got, input word_t want);
        errorCount++;
        $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, want);
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("Failure at %0d ns: %s", $time, what);
    endtask

    task automatic putInsn(input word_t insn);
        imem[wordIndex(buildPc)] = insn;
        buildPc = buildPc + 1;
    endtask

    task automatic putStore(input regIdx_t z);
        putInsn(encodeInsn(FL_STORE, z, 4'd0, 4'd0, opOr, imm_t'(storeSlot)));
        storeSlot = storeSlot + 1;
    endtask

    task automatic putAluPair(input logic [3:0] op, input logic kind);
        regIdx_t z;
        regIdx_t x;
        regIdx_t y;
        z = regIdx_t'($urandom_range(14, 1));
        x = regIdx_t'($urandom_range(14, 0));
        y = ($urandom_range(3, 0) == 0) ? x : regIdx_t'($urandom_range(15, 0));
        putInsn(encodeInsn({1'b0, kind, 2'b00}, z, x, y, op, imm_t'($urandom)));
        putStore(z);
    endtask

    task automatic buildProgram();
        word_t      branchAt;
        word_t      throwAt;
        logic [4:0] vec;
        for (int a = 0; a < MEM_WORDS; a++) begin
            imem[a] = word_t'(a);               // OR into register 0, harmless
            dmem[a] = $urandom;
        end
        buildPc   = RESET_VECTOR;
        storeSlot = 32'h40;
        for (int r = 1; r < 15; r++) begin
            putInsn(encodeInsn(FL_LOAD, regIdx_t'(r), 4'd0, 4'd0, opOr, imm_t'(12'h380 + r)));
        end
        putStore(4'd0);
        for (int op = 0; op < 16; op++) begin
            putAluPair(4'(op), 1'b0);
            putAluPair(4'(op), 1'b1);
        end
        putInsn(encodeInsn(FL_LOAD, 4'd3, 4'd0, 4'd0, opOr, 12'h3f0));
        putStore(4'd3);
        branchAt = buildPc;                     // Jump over two slots
        putInsn(encodeInsn(FL_NONE, PC_INDEX, 4'd0, 4'd0, opAdd, imm_t'(branchAt + 3)));
        buildPc = branchAt + 3;
        putStore(PC_INDEX);
        vec     = 5'($urandom_range(31, 0));
        throwAt = buildPc;
        putInsn(encodeInsn(FL_THROW, 4'd0, 4'd0, 4'd0, opOr, imm_t'(vec)));
        dmem[wordIndex(VECTOR_BASE + word_t'(vec))] = throwAt + 2;
        buildPc = throwAt + 2;
        putStore(4'd5);
        timerStart = buildPc;
        trapPeriod = timerCount_t'($urandom_range(80, 40));
        for (int i = 0; i < TIMED_PAIRS; i++) begin
            putAluPair(4'($urandom_range(15, 0)), 1'($urandom_range(1, 0)));
        end
        endAddr = buildPc;                      // Jump to itself
        putInsn(encodeInsn(FL_NONE, PC_INDEX, 4'd0, 4'd0, opOr, imm_t'(endAddr)));
        // Handler resumes at the interrupted address
        imem[wordIndex(TRAMP_BOTTOM)] =
            encodeInsn(FL_LOAD, PC_INDEX, 4'd0, 4'd0, opOr, imm_t'(TRAP_ADDR));
        for (int a = 0; a < MEM_WORDS; a++) begin
            refMem[a] = dmem[a];
        end
        for (int r = 0; r < 16; r++) begin
            refRegs[r] = '0;
        end
        refPc      = RESET_VECTOR;
        programLen = buildPc - RESET_VECTOR + 1;
    endtask

    // Sampled on the falling edge where DUT outputs are settled
    always @(negedge clk) begin
        if (reset_n) begin
            if (dut0.execEn) begin
                if (pendingInsn) begin
                    refStep(curInsn, expIsStore, expAddr, expData);
                    if (expIsStore) begin
                        reportFailure("expected store did not happen before the next fetch");
                    end
                end
                if (iAddr !== refPc) begin
                    reportMismatch("iAddr", iAddr, refPc);
                end
                curInsn     = imem[wordIndex(refPc)];
                pendingInsn = 1'b1;
                fetchCount++;
                if (refPc == timerStart) begin
                    timerPhase = 1'b1;
                end
                if (refPc == endAddr) begin
                    progDone = 1'b1;
                end
            end else if (strobe && !memRw && pendingInsn && curInsn[31] && curInsn[30]) begin
                if (dAddr !== VECTOR_BASE + word_t'(curInsn[4:0])) begin
                    reportMismatch("dAddr", dAddr, VECTOR_BASE + word_t'(curInsn[4:0]));
                end
            end else if (strobe && memRw) begin
                if (!pendingInsn) begin
                    reportFailure("data write with no instruction in flight");
                end else if (dAddr == TRAP_ADDR && !(curInsn[31] && curInsn[30])) begin
                    if (dOut !== refPc) begin   // Timer trap, fetched word not run
                        reportMismatch("dOut", dOut, refPc);
                    end
                    refMem[wordIndex(TRAP_ADDR)] = refPc;
                    refPc       = TRAMP_BOTTOM;
                    pendingInsn = 1'b0;
                    trapCount++;
                end else begin
                    refStep(curInsn, expIsStore, expAddr, expData);
                    pendingInsn = 1'b0;
                    storeCount++;
                    if (!expIsStore) begin
                        reportFailure("data write from an instruction that does not store");
                    end else begin
                        if (dAddr !== expAddr) begin
                            reportMismatch("dAddr", dAddr, expAddr);
                        end
                        if (dOut !== expData) begin
                            reportMismatch("dOut", dOut, expData);
                        end
                    end
                end
            end else if (strobe) begin
                // Only loads may read outside a throw
                if (!pendingInsn || curInsn[29] || !curInsn[28]) begin
                    reportFailure("data read from an instruction that does not load");
                end
            end
        end
    end

    initial begin
        seedValue   = $urandom(SEED);
        reset_n     = 1'b0;
        halt        = 1'b1;
        timerPeriod = '0;
        errorCount  = 0;
        fetchCount  = 0;
        storeCount  = 0;
        trapCount   = 0;
        pendingInsn = 1'b0;
        timerPhase  = 1'b0;
        progDone    = 1'b0;
        buildProgram();
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            if (strobe !== 1'b0) begin
                reportFailure("strobe went high while halted");
            end
            if (dut0.execEn) begin
                reportFailure("core left idle while halted");
            end
        end
        halt = 1'b0;
        wait (timerPhase);
        @(negedge clk);
        timerPeriod = trapPeriod;
        wait (progDone);
        @(negedge clk);
        timerPeriod = '0;
        halt        = 1'b1;                     // Park the core
        repeat (4) @(negedge clk);
        if (trapCount == 0) begin
            reportFailure("timer never raised a trap");
        end
        $display("Fetches %0d, stores %0d, traps %0d, errors %0d",
                 fetchCount, storeCount, trapCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Twice the nominal six cycles per instruction
    initial begin
        wait (programLen != 0);
        #((programLen * 12 + RESET_CYCLES + HALT_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the program did not reach its end in time");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
logic/cpuIsaPkg.sv
logic/cpuSysPkg.sv
logic/decodeIf.sv
logic/insnDecoder.sv
logic/regFile.sv
logic/aluExec.sv
logic/cycleTimer.sv
logic/coreControl.sv
logic/cpuCore.sv
dv/cpuCoreTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cpuCoreTb
FILELIST = src.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD)
